// ==== sources.f ====
verilog/cache_pkg.sv
verilog/cache_tag.sv
verilog/cache_data.sv
verilog/cache_victim.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
sim/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_tag.sv
  - verilog/cache_data.sv
  - verilog/cache_victim.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - sim/cache_tb.sv

// ==== sim/cache_tb.sv ====
// cache testbench
// directed tests against a sparse memory model
module cache_tb;
    import cache_pkg::*;

    logic     clk_i;
    logic     rst_i;
    cpu_req_t cpu_req;
    cpu_res_t cpu_res;
    mem_req_t mem_req;
    mem_res_t mem_res;

    // memory model, unwritten words follow the address
    word_t    mem_words [addr_t];
    int       mem_reads;
    int       mem_writes;
    int       lat_cnt;
    addr_t    last_addr;
    word_t    last_wdata;

    int       errors;
    int       checks;
    logic     timed_out;

    cache_top dut_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cpu_req_i (cpu_req),
        .cpu_res_o (cpu_res),
        .mem_req_o (mem_req),
        .mem_res_i (mem_res)
    );

    always #20 clk_i = ~clk_i;

    function automatic word_t mem_word(input addr_t addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ 32'h5a3c_96e1;
    endfunction

    // tag t in set 0x155
    function automatic addr_t set_addr(input int t);
        return {tag_t'(t + 'h300), index_t'(10'h155), 2'b00};
    endfunction

    // memory port, random 1 to 4 cycle latency per request
    always @(negedge clk_i) begin
        mem_res = '0;
        if (!rst_i && mem_req.valid) begin
            if (lat_cnt == 0) begin
                lat_cnt = $urandom % 4 + 1;
            end
            lat_cnt = lat_cnt - 1;
            if (lat_cnt == 0) begin
                mem_res.ready = 1'b1;
                last_addr     = mem_req.addr;
                if (mem_req.rw) begin
                    mem_words[mem_req.addr] = mem_req.data;
                    last_wdata = mem_req.data;
                    mem_writes++;
                end else begin
                    mem_res.data = mem_word(mem_req.addr);
                    mem_reads++;
                end
            end
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (!timed_out) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("ERR @ %0t: %s, got %h expected %h", $time, msg, got, exp);
            end
        end
    endtask

    // one request, cycles counts falling edges until ready
    task automatic cpu_access(input logic rw, input addr_t addr, input word_t wdata,
                              output word_t rdata, output int cycles);
        rdata  = '0;
        cycles = 0;
        if (!timed_out) begin
            @(negedge clk_i);
            cpu_req = '{valid: 1'b1, rw: rw, addr: addr, data: wdata};
            do begin
                @(negedge clk_i);
                cycles++;
            end while (!cpu_res.ready && cycles < 200);
            if (cpu_res.ready) begin
                rdata = cpu_res.data;
            end else begin
                timed_out = 1'b1;
                $display("timeout: no cpu ready within 200 cycles of request to %h", addr);
            end
            cpu_req = '0;
        end
    endtask

    task automatic check_reset();
        rst_i = 1'b1;
        repeat (4) begin
            @(negedge clk_i);
            check(cpu_res.ready, 1'b0, "cpu ready during reset");
            check(mem_req.valid, 1'b0, "mem valid during reset");
        end
        rst_i = 1'b0;
        @(negedge clk_i);
        check(cpu_res.ready, 1'b0, "cpu ready after reset");
        check(mem_req.valid, 1'b0, "mem valid after reset");
    endtask

    task automatic read_miss_then_hit(input addr_t a);
        word_t d;
        int    n;
        int    reads;
        reads = mem_reads;
        cpu_access(1'b0, a, '0, d, n);
        check(mem_reads - reads, 1, "read miss memory reads");
        check(last_addr, a, "read miss memory address");
        check(d, mem_word(a), "read miss data");
        reads = mem_reads;
        cpu_access(1'b0, a, '0, d, n);
        check(mem_reads - reads, 0, "read hit memory reads");
        check(d, mem_word(a), "read hit data");
        check(n, 2, "read hit latency");
    endtask

    // exp_reads is 0 for a cached address, 1 when the write did not allocate
    task automatic write_then_read(input addr_t a, input word_t w, input int exp_reads);
        word_t d;
        int    n;
        int    writes;
        int    reads;
        writes = mem_writes;
        cpu_access(1'b1, a, w, d, n);
        check(mem_writes - writes, 1, "write-through memory writes");
        check(last_addr, a, "write-through address");
        check(last_wdata, w, "write-through data");
        reads = mem_reads;
        cpu_access(1'b0, a, '0, d, n);
        check(mem_reads - reads, exp_reads, "read after write memory reads");
        check(d, w, "read after write data");
    endtask

    task automatic round_robin_evict();
        word_t d;
        int    n;
        int    t;
        int    reads;
        reads = mem_reads;
        // eight free ways fill first, ninth lands on way 0
        for (t = 0; t < 9; t++) begin
            cpu_access(1'b0, set_addr(t), '0, d, n);
            check(d, mem_word(set_addr(t)), "set fill data");
        end
        check(mem_reads - reads, 9, "set fill memory reads");
        reads = mem_reads;
        for (t = 1; t < 9; t++) begin
            cpu_access(1'b0, set_addr(t), '0, d, n);
        end
        check(mem_reads - reads, 0, "surviving ways hit");
        reads = mem_reads;
        cpu_access(1'b0, set_addr(0), '0, d, n);
        check(mem_reads - reads, 1, "first address evicted");
    endtask

    // ten tags over three sets, so sets overflow and evict
    task automatic random_traffic();
        addr_t a;
        word_t w;
        word_t d;
        int    n;
        int    i;
        for (i = 0; i < 200; i++) begin
            a = {tag_t'($urandom % 10 + 'h500), index_t'($urandom % 3 + 'h2f0), 2'b00};
            if ($urandom % 2) begin
                w = $urandom;
                cpu_access(1'b1, a, w, d, n);
                check(mem_word(a), w, "random write reached memory");
            end else begin
                cpu_access(1'b0, a, '0, d, n);
                check(d, mem_word(a), "random read data");
            end
        end
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        cpu_req    = '0;
        mem_res    = '0;
        mem_reads  = 0;
        mem_writes = 0;
        lat_cnt    = 0;
        last_addr  = '0;
        last_wdata = '0;
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        void'($urandom(32'he32ab62b));
        check_reset();
        read_miss_then_hit(32'h0001_2344);
        write_then_read(32'h0001_2344, 32'hc0de_0001, 0);
        write_then_read(32'h0007_7720, 32'hbeef_0002, 1);
        round_robin_evict();
        random_traffic();
        $display("%0d checks, %0d errors, %0d memory reads, %0d memory writes",
                 checks, errors, mem_reads, mem_writes);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cache_top.sv ====
// 8-way set-associative cache
module cache_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  cache_pkg::cpu_req_t cpu_req_i,
    output cache_pkg::cpu_res_t cpu_res_o,
    output cache_pkg::mem_req_t mem_req_o,
    input  cache_pkg::mem_res_t mem_res_i
);
    import cache_pkg::*;

    // controller to tag store
    cache_req_type tag_req;
    cache_tag_type tag_write;
    tag_t          tag_addr;
    // lookup results
    logic          hit;
    way_t          way;
    way_t          free_way;
    logic          full;
    way_t          victim_way;
    // data store side
    way_t          data_way;
    logic          data_we;
    word_t         data_wdata;
    word_t         rdata;
    logic          advance;

    cache_ctrl ctrl_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_res_o    (cpu_res_o),
        .mem_req_o    (mem_req_o),
        .mem_res_i    (mem_res_i),
        .tag_req_o    (tag_req),
        .tag_write_o  (tag_write),
        .tag_o        (tag_addr),
        .hit_i        (hit),
        .way_i        (way),
        .data_way_o   (data_way),
        .data_we_o    (data_we),
        .data_wdata_o (data_wdata),
        .rdata_i      (rdata),
        .advance_o    (advance)
    );

    // stored entry is not needed by the controller
    cache_tag tag_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .tag_req_i     (tag_req),
        .tag_write_i   (tag_write),
        .address_way_i (victim_way),
        .cpu_address_i (tag_addr),
        .address_way_o (way),
        .tag_read_o    (),
        .hit_o         (hit),
        .free_way_o    (free_way),
        .full_o        (full)
    );

    // data store shares the lookup index
    cache_data data_i (
        .clk_i   (clk_i),
        .index_i (tag_req.index),
        .way_i   (data_way),
        .we_i    (data_we),
        .wdata_i (data_wdata),
        .rdata_o (rdata)
    );

    cache_victim victim_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (tag_req.index),
        .full_i       (full),
        .free_way_i   (free_way),
        .advance_i    (advance),
        .victim_way_o (victim_way)
    );

endmodule

// ==== verilog/cache_ctrl.sv ====
// cache controller
// lookup, refill and write-through sequencing
module cache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  cache_pkg::cpu_req_t      cpu_req_i,
    output cache_pkg::cpu_res_t      cpu_res_o,
    output cache_pkg::mem_req_t      mem_req_o,
    input  cache_pkg::mem_res_t      mem_res_i,
    output cache_pkg::cache_req_type tag_req_o,
    output cache_pkg::cache_tag_type tag_write_o,
    output cache_pkg::tag_t          tag_o,
    input  logic                     hit_i,
    input  cache_pkg::way_t          way_i,
    output cache_pkg::way_t          data_way_o,
    output logic                     data_we_o,
    output cache_pkg::word_t         data_wdata_o,
    input  cache_pkg::word_t         rdata_i,
    output logic                     advance_o
);
    import cache_pkg::*;

    cache_state_t state_q;
    cache_state_t state_d;

    // latched cpu request and refill word
    cpu_req_t req_q;
    word_t    mem_word_q;
    // response source, memory word vs data store
    logic     from_mem_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req_i.valid) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                // writes always go through to memory
                if (req_q.rw) begin
                    state_d = MEM_WRITE;
                end else if (hit_i) begin
                    state_d = RESPOND;
                end else begin
                    state_d = MEM_READ;
                end
            end
            MEM_READ: begin
                if (mem_res_i.ready) begin
                    state_d = REFILL;
                end
            end
            MEM_WRITE: begin
                if (mem_res_i.ready) begin
                    state_d = RESPOND;
                end
            end
            REFILL:  state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            from_mem_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == COMPARE) begin
                from_mem_q <= 1'b0;
            end else if (state_q == REFILL) begin
                from_mem_q <= 1'b1;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cpu_req_i.valid) begin
            req_q <= cpu_req_i;
        end
        if (state_q == MEM_READ && mem_res_i.ready) begin
            mem_word_q <= mem_res_i.data;
        end
    end

    // tag store, lookup every cycle, write only on refill
    assign tag_req_o.index   = req_q.addr[TAGLSB-1:TAGLSB-INDEX];
    assign tag_req_o.we      = (state_q == REFILL);
    assign tag_write_o.valid = 1'b1;
    assign tag_write_o.tag   = req_q.addr[TAGMSB:TAGLSB];
    assign tag_o             = req_q.addr[TAGMSB:TAGLSB];

    // data store
    // compare: read the hit way, or update it on a write hit
    // refill: way_i is the victim since the lookup missed
    assign data_way_o   = way_i;
    assign data_we_o    = (state_q == REFILL) ||
                          (state_q == COMPARE && req_q.rw && hit_i);
    assign data_wdata_o = (state_q == REFILL) ? mem_word_q : req_q.data;
    assign advance_o    = (state_q == REFILL);

    // memory port, word aligned address held until ready
    assign mem_req_o.valid = (state_q == MEM_READ) || (state_q == MEM_WRITE);
    assign mem_req_o.rw    = (state_q == MEM_WRITE);
    assign mem_req_o.addr  = {req_q.addr[31:2], 2'b00};
    assign mem_req_o.data  = req_q.data;

    // cpu response, one cycle pulse
    assign cpu_res_o.ready = (state_q == RESPOND);
    assign cpu_res_o.data  = from_mem_q ? mem_word_q : rdata_i;

endmodule

// ==== verilog/cache_victim.sv ====
// refill way picker
// free way first, round-robin once the set is full
module cache_victim (
    input  logic             clk_i,
    input  logic             rst_i,
    input  cache_pkg::index_t index_i,
    input  logic             full_i,
    input  cache_pkg::way_t   free_way_i,
    input  logic             advance_i,
    output cache_pkg::way_t   victim_way_o
);
    import cache_pkg::*;

    // round-robin pointer per set
    way_t ptr_q [DEPTH];
    way_t cur_ptr;

    assign cur_ptr = ptr_q[index_i];

    // free way while the set has room
    assign victim_way_o = full_i ? cur_ptr : free_way_i;

    // pointer moves only when a full set gets refilled
    // 3-bit add wraps at 8
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < DEPTH; s++) begin
                ptr_q[s] <= '0;
            end
        end else if (advance_i && full_i) begin
            ptr_q[index_i] <= cur_ptr + way_t'(1);
        end
    end

endmodule

// ==== verilog/cache_data.sv ====
// cache data store
module cache_data (
    input  logic             clk_i,
    input  cache_pkg::index_t index_i,
    input  cache_pkg::way_t   way_i,
    input  logic             we_i,
    input  cache_pkg::word_t  wdata_i,
    output cache_pkg::word_t  rdata_o
);
    import cache_pkg::*;

    // one word per way per set
    word_t mem [DEPTH][WAYS];
    word_t rdata_q;

    // single port
    // write when enabled, read registered every cycle
    // a read in the write cycle returns the old word
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[index_i][way_i] <= wdata_i;
        end
        rdata_q <= mem[index_i][way_i];
    end

    assign rdata_o = rdata_q;

endmodule

// ==== verilog/cache_tag.sv ====
// cache tag store
// 8-way compare, single write port
module cache_tag (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  cache_pkg::cache_req_type tag_req_i,
    input  cache_pkg::cache_tag_type tag_write_i,
    input  cache_pkg::way_t          address_way_i,
    input  cache_pkg::tag_t          cpu_address_i,
    output cache_pkg::way_t          address_way_o,
    output cache_pkg::cache_tag_type tag_read_o,
    output logic                     hit_o,
    output cache_pkg::way_t          free_way_o,
    output logic                     full_o
);
    import cache_pkg::*;

    // valid bits per set, one bit per way
    logic [WAYS-1:0] valid_q [DEPTH];
    // tags carry no reset
    tag_t            tag_mem [DEPTH][WAYS];

    index_t          idx;
    logic [WAYS-1:0] set_valid;
    logic [WAYS-1:0] hit_vec;
    way_t            sel_way;
    way_t            free_way;

    assign idx       = tag_req_i.index;
    assign set_valid = valid_q[idx];

    // tag compare on all ways, gated by valid
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = set_valid[w] && (tag_mem[idx][w] == cpu_address_i);
        end
    end

    // priority select, lowest matching way wins
    // no hit falls back to the victim way from outside
    always_comb begin
        sel_way = address_way_i;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                sel_way = way_t'(w);
            end
        end
    end

    // lowest invalid way, 0 when the set is full
    always_comb begin
        free_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = way_t'(w);
            end
        end
    end

    assign hit_o         = |hit_vec;
    assign full_o        = &set_valid;
    assign free_way_o    = free_way;
    // selected way doubles as the write way
    assign address_way_o = sel_way;
    assign tag_read_o    = '{valid: set_valid[sel_way], tag: tag_mem[idx][sel_way]};

    // valid bits, cleared on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < DEPTH; s++) begin
                valid_q[s] <= '0;
            end
        end else if (tag_req_i.we) begin
            valid_q[idx][sel_way] <= tag_write_i.valid;
        end
    end

    // tag write into the hit way, else the victim way
    always_ff @(posedge clk_i) begin
        if (tag_req_i.we) begin
            tag_mem[idx][sel_way] <= tag_write_i.tag;
        end
    end

endmodule

// ==== verilog/cache_pkg.sv ====
// 8-way cache shared types
// geometry, address fields and port structs
package cache_pkg;

    // geometry, fixed at eight ways of one-word blocks
    localparam int WAYS      = 8;
    localparam int INDEX_WAY = 3;
    localparam int DEPTH     = 1024;
    localparam int INDEX     = 10;
    // address split: tag 31:12, index 11:2, byte offset 1:0
    localparam int TAGLSB    = 12;
    localparam int TAGMSB    = 31;

    typedef logic [31:0]              addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [INDEX-1:0]         index_t;
    typedef logic [TAGMSB-TAGLSB:0]   tag_t;
    typedef logic [INDEX_WAY-1:0]     way_t;

    // tag store lookup / write request
    typedef struct packed {
        index_t index;
        logic   we;
    } cache_req_type;

    // one tag entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cache_tag_type;

    // cpu side, rw high means write
    typedef struct packed {
        logic  valid;
        logic  rw;
        addr_t addr;
        word_t data;
    } cpu_req_t;

    typedef struct packed {
        logic  ready;
        word_t data;
    } cpu_res_t;

    // memory side, same shape as the cpu port
    typedef struct packed {
        logic  valid;
        logic  rw;
        addr_t addr;
        word_t data;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        word_t data;
    } mem_res_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        MEM_READ,
        MEM_WRITE,
        REFILL,
        RESPOND
    } cache_state_t;

endpackage
